//--- filelist.f
+incdir+include
hdl/video_pkg.sv
hdl/pixel_stream_if.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/line_fetch.sv
hdl/pixel_fifo.sv
hdl/pixel_shifter.sv
hdl/video_gen_top.sv
tb/tb_video_gen.sv

//--- run.sh
#!/bin/sh
# build and run the video generator testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_video_gen -f filelist.f -o sim_video_gen
./obj_dir/sim_video_gen | tee sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/tb_video_gen.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_video_gen;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES + 500;

    logic              clk;
    logic              reset_i;
    logic              reg_wr_i;
    logic [2:0]        reg_num_i;
    video_pkg::word_t  reg_data_i;
    video_pkg::word_t  reg_data_o;
    logic              mem_req_o;
    video_pkg::addr_t  mem_addr_o;
    logic              mem_ack_i;
    video_pkg::word_t  mem_data_i;
    video_pkg::color_t color_index_o;
    logic              hsync_o;
    logic              vsync_o;
    logic              de_o;
    logic              frame_intr_o;

    logic              slow_mem;                    // memory answers after 10 to 15 cycles
    int                mem_wait;
    int                errors;
    int                checks;
    int                tests_run;
    int                cycles;

    // expected configuration decoded from the last register writes
    video_pkg::color_t cfg_border;
    video_pkg::color_t cfg_cbase;
    logic              cfg_blank;
    logic              cfg_bpp8;
    video_pkg::addr_t  cfg_disp;
    video_pkg::word_t  cfg_len;

    video_gen_top u_video_gen_top (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .de_o(de_o), .frame_intr_o(frame_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    end

    // video ram model answering the four-phase req/ack with address xor 5a3c
    initial begin
        void'($urandom(32'hfe57));
        mem_ack_i  = 1'b0;
        mem_data_i = '0;
        mem_wait   = 0;
        forever begin
            @(negedge clk);
            if (mem_req_o && !mem_ack_i) begin
                if (mem_wait == 0) begin
                    mem_wait = slow_mem ? 10 + int'($urandom % 6) : 1;
                end
                mem_wait = mem_wait - 1;
                if (mem_wait == 0) begin
                    mem_ack_i  = 1'b1;
                    mem_data_i = mem_addr_o ^ 16'h5a3c;
                end
            end else if (!mem_req_o && mem_ack_i) begin
                mem_ack_i = 1'b0;                   // release after the request drops
            end
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [2:0] num, input video_pkg::word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i   = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [2:0] num,
                             input video_pkg::word_t expected);
        reg_num_i = num;
        @(negedge clk);                             // one cycle read latency
        check_value(name, expected, reg_data_o);
    endtask

    task automatic configure(input video_pkg::word_t vid, input video_pkg::word_t gfx,
                             input video_pkg::addr_t disp, input video_pkg::word_t len);
        write_reg(`REG_VID_CTRL, vid);
        write_reg(`REG_GFX_CTRL, gfx);
        write_reg(`REG_DISP_ADDR, disp);
        write_reg(`REG_LINE_LEN, len);
        cfg_border = vid[7:0];
        cfg_cbase  = gfx[15:8];
        cfg_blank  = gfx[7];
        cfg_bpp8   = gfx[4];
        cfg_disp   = disp;
        cfg_len    = len;
    endtask

    // returns on the first sample of a frame when vsync_o has just risen
    task automatic wait_frame_start();
        logic prev;
        prev = vsync_o;
        @(negedge clk);
        while (!(vsync_o && !prev)) begin
            prev = vsync_o;
            @(negedge clk);
        end
    endtask

    // checks one whole frame; sample n shows raster position n
    task automatic check_frame(input string name, input logic starved_ok, output int starved);
        int                n;
        int                h;
        int                v;
        int                x;
        int                shown;
        int                hsync_rises;
        int                intr_pulses;
        logic              prev_hsync;
        logic              visible;
        video_pkg::addr_t  addr;
        video_pkg::word_t  word;
        video_pkg::color_t exp_pix;
        wait_frame_start();
        starved     = 0;
        shown       = 0;
        hsync_rises = 0;
        intr_pulses = 0;
        prev_hsync  = 1'b0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            h       = n % `H_TOTAL;
            v       = n / `H_TOTAL;
            visible = (h >= `H_BLANK) && (v >= `V_BLANK);
            exp_pix = cfg_border;
            if (visible && !cfg_blank) begin
                x    = h - `H_BLANK;
                addr = cfg_disp + 16'(v - `V_BLANK) * cfg_len + 16'(x / (cfg_bpp8 ? 2 : 4));
                word = addr ^ 16'h5a3c;
                if (cfg_bpp8) begin
                    exp_pix = 8'(word >> (8 - 8 * (x % 2)));      // first pixel high byte
                end else begin
                    exp_pix = 8'((word >> (12 - 4 * (x % 4))) & 16'h000f);
                end
                exp_pix = exp_pix ^ cfg_cbase;
            end
            check_value({name, " de"}, 16'(visible), 16'(de_o));
            check_value({name, " hsync"}, 16'(h >= `HSYNC_START && h <= `HSYNC_END),
                        16'(hsync_o));
            check_value({name, " vsync"}, 16'(v == `VSYNC_LINE), 16'(vsync_o));
            if (visible && !cfg_blank && starved_ok) begin
                if (color_index_o == cfg_border) begin
                    starved++;                      // late words shift the picture so count border only
                end
            end else begin
                check_value($sformatf("%s color at h %0d v %0d", name, h, v),
                            16'(exp_pix), 16'(color_index_o));
            end
            if (de_o) begin
                shown++;
            end
            if (hsync_o && !prev_hsync) begin
                hsync_rises++;
            end
            prev_hsync = hsync_o;
            if (frame_intr_o) begin
                intr_pulses++;
            end
        end
        check_value({name, " visible pixels"}, 16'(`H_VISIBLE * `V_VISIBLE), 16'(shown));
        check_value({name, " hsync pulses"}, 16'(`V_TOTAL), 16'(hsync_rises));
        check_value({name, " frame interrupts"}, 16'd1, 16'(intr_pulses));
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d failed checks", name, errors - err0);
        end
        tests_run++;
    endtask

    task automatic test_reset_readback();
        int i;
        int err0;
        err0 = errors;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("reset_readback de in reset", 16'h0000, 16'(de_o));
            check_value("reset_readback hsync in reset", 16'h0000, 16'(hsync_o));
            check_value("reset_readback vsync in reset", 16'h0000, 16'(vsync_o));
            check_value("reset_readback color in reset", 16'h0000, 16'(color_index_o));
        end
        reset_i = 1'b0;
        check_reg("reset_readback vid_ctrl reset", `REG_VID_CTRL, 16'h0008);
        check_reg("reset_readback gfx_ctrl reset", `REG_GFX_CTRL, 16'h0090); // blank and 8 bpp
        check_reg("reset_readback disp_addr reset", `REG_DISP_ADDR, 16'h0000);
        check_reg("reset_readback line_len reset", `REG_LINE_LEN, 16'd16);
        check_reg("reset_readback status reset", `REG_STATUS, 16'h0000);    // still on line 0
        write_reg(`REG_VID_CTRL, 16'habcd);
        check_reg("reset_readback vid_ctrl", `REG_VID_CTRL, 16'h00cd);
        write_reg(`REG_GFX_CTRL, 16'hffff);
        check_reg("reset_readback gfx_ctrl", `REG_GFX_CTRL, 16'hff90);
        write_reg(`REG_DISP_ADDR, 16'h1234);
        check_reg("reset_readback disp_addr", `REG_DISP_ADDR, 16'h1234);
        write_reg(`REG_LINE_LEN, 16'h0028);
        check_reg("reset_readback line_len", `REG_LINE_LEN, 16'h0028);
        wait_frame_start();
        repeat (3 * `H_TOTAL + 9) @(negedge clk);   // raster now at h 10 of line 3
        check_reg("reset_readback status line", `REG_STATUS, 16'h0003);
        finish_test("reset_readback", err0);
    endtask

    task automatic test_8bpp_fast();
        int err0;
        int starved;
        err0 = errors;
        wait_frame_start();                         // keep writes away from frame end
        configure(16'h00e7, 16'h3c10, 16'h0000, 16'd16);
        check_frame("8bpp_fast", 1'b0, starved);
        finish_test("8bpp_fast", err0);
    endtask

    task automatic test_4bpp_offset();
        int err0;
        int starved;
        err0 = errors;
        configure(16'h00e7, 16'ha500, 16'd100, 16'd40);
        check_frame("4bpp_offset", 1'b0, starved);
        finish_test("4bpp_offset", err0);
    endtask

    task automatic test_blank();
        int err0;
        int starved;
        err0 = errors;
        configure(16'h0042, 16'ha590, 16'd100, 16'd40);
        check_frame("blank", 1'b0, starved);
        finish_test("blank", err0);
    endtask

    task automatic test_underrun();
        int err0;
        int starved;
        err0 = errors;
        slow_mem = 1'b1;
        configure(16'h00e7, 16'h3c10, 16'h0000, 16'd16);
        check_frame("underrun", 1'b1, starved);
        checks++;
        assert (starved > 0) else begin
            $display("underrun: slow memory never made a visible pixel fall back to border");
            errors++;
        end
        check_reg("underrun status set", `REG_STATUS, 16'h8000);   // vertical blank on line 0
        write_reg(`REG_STATUS, 16'h0000);
        check_reg("underrun status cleared", `REG_STATUS, 16'h0000);
        finish_test("underrun", err0);
    endtask

    initial begin
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = '0;
        reg_data_i = '0;
        slow_mem   = 1'b0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        test_reset_readback();
        test_8bpp_fast();
        test_4bpp_offset();
        test_blank();
        test_underrun();
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- hdl/video_gen_top.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_gen_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              reg_wr_i,
    input  logic [2:0]        reg_num_i,
    input  video_pkg::word_t  reg_data_i,
    output video_pkg::word_t  reg_data_o,
    output logic              mem_req_o,
    output video_pkg::addr_t  mem_addr_o,
    input  logic              mem_ack_i,
    input  video_pkg::word_t  mem_data_i,
    output video_pkg::color_t color_index_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              de_o,
    output logic              frame_intr_o
);

    logic [`H_BITS-1:0] h_count;
    logic [`V_BITS-1:0] v_count;
    logic               h_visible;
    logic               v_visible;
    logic               hsync;
    logic               vsync;
    logic               frame_end;
    logic               visible_end;
    logic               underrun;
    video_pkg::color_t  border;
    video_pkg::color_t  colorbase;
    logic               blank;
    video_pkg::bpp_t    bpp;
    video_pkg::addr_t   disp_addr;
    video_pkg::word_t   line_len;

    pixel_stream_if u_stream ();

    video_timing u_video_timing (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count),
        .h_visible_o(h_visible), .v_visible_o(v_visible),
        .hsync_o(hsync), .vsync_o(vsync),
        .line_end_o(),                              // only used inside the timing block
        .frame_end_o(frame_end), .visible_end_o(visible_end)
    );

    video_regs u_video_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .v_count_i(v_count), .visible_end_i(visible_end), .underrun_i(underrun),
        .border_o(border), .colorbase_o(colorbase), .blank_o(blank), .bpp_o(bpp),
        .disp_addr_o(disp_addr), .line_len_o(line_len), .frame_intr_o(frame_intr_o)
    );

    line_fetch u_line_fetch (
        .clk(clk), .reset_i(reset_i), .frame_end_i(frame_end),
        .bpp_i(bpp), .disp_addr_i(disp_addr), .line_len_i(line_len),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i),
        .s(u_stream.fetch)
    );

    pixel_fifo u_pixel_fifo (
        .clk(clk), .reset_i(reset_i), .s(u_stream.fifo)
    );

    pixel_shifter u_pixel_shifter (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .h_visible_i(h_visible), .v_visible_i(v_visible),
        .hsync_i(hsync), .vsync_i(vsync),
        .border_i(border), .colorbase_i(colorbase), .blank_i(blank), .bpp_i(bpp),
        .s(u_stream.shifter),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .de_o(de_o), .underrun_o(underrun)
    );

endmodule

//--- hdl/pixel_shifter.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module pixel_shifter (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [`H_BITS-1:0] h_count_i,
    input  logic               h_visible_i,
    input  logic               v_visible_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    input  video_pkg::color_t  border_i,
    input  video_pkg::color_t  colorbase_i,
    input  logic               blank_i,
    input  video_pkg::bpp_t    bpp_i,
    pixel_stream_if.shifter    s,
    output video_pkg::color_t  color_index_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic               underrun_o
);

    logic [`H_BITS-1:0]   col;                      // visible pixel column
    video_pkg::pix_word_u head;
    video_pkg::color_t    pixel;
    logic                 last_slot;                // last pixel of the head word
    logic                 active;

    assign col    = h_count_i - `H_BITS'(`H_BLANK);
    assign head   = s.head_data;
    assign active = h_visible_i && v_visible_i && !blank_i;

    always_comb begin
        if (bpp_i) begin
            pixel     = head.p8[~col[0]];           // slot 0 is the high byte
            last_slot = col[0];
        end else begin
            pixel     = {4'h0, head.p4[~col[1:0]]};
            last_slot = &col[1:0];
        end
    end

    assign s.pop      = active && !s.empty && last_slot;
    assign underrun_o = active && s.empty;          // fifo starved on a shown pixel

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            de_o          <= 1'b0;
        end else begin
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= h_visible_i && v_visible_i;
            if (active && !s.empty) begin
                color_index_o <= pixel ^ colorbase_i;
            end else begin
                color_index_o <= border_i;          // border, blank or underrun
            end
        end
    end

endmodule

//--- hdl/pixel_fifo.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module pixel_fifo (
    input  logic         clk,
    input  logic         reset_i,
    pixel_stream_if.fifo s
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    video_pkg::word_t   mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign do_push     = s.push && !s.full && !s.flush;
    assign do_pop      = s.pop && !s.empty;
    assign s.full      = count == (PTR_W + 1)'(`FIFO_DEPTH);
    assign s.empty     = count == '0;
    assign s.head_data = mem[rd_ptr];               // show-ahead

    always_ff @(posedge clk) begin
        if (reset_i || s.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;            // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= s.push_data;
        end
    end

endmodule

//--- hdl/line_fetch.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module line_fetch (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             frame_end_i,
    input  video_pkg::bpp_t  bpp_i,
    input  video_pkg::addr_t disp_addr_i,
    input  video_pkg::word_t line_len_i,
    output logic             mem_req_o,
    output video_pkg::addr_t mem_addr_o,
    input  logic             mem_ack_i,
    input  video_pkg::word_t mem_data_i,
    pixel_stream_if.fetch    s
);

    video_pkg::addr_t line_addr;                    // first word of current line
    video_pkg::addr_t fetch_addr;                   // next word to request
    logic [3:0]       word_cnt;
    logic [3:0]       word_last;
    logic [1:0]       line_cnt;
    logic             fetch_on;                     // frame not fully fetched yet
    logic             ack_wait;                     // data taken, waiting for ack low
    logic             discard;                      // request issued before a flush
    logic             can_fetch;
    logic             capture;
    logic             issue;

    assign word_last = bpp_i ? 4'(`H_VISIBLE / 2 - 1) : 4'(`H_VISIBLE / 4 - 1);
    assign can_fetch = fetch_on && !s.full && !frame_end_i;
    assign capture   = mem_req_o && mem_ack_i;
    assign issue     = !mem_req_o && !(ack_wait && mem_ack_i) && can_fetch;

    assign s.push      = capture && !discard;
    assign s.push_data = mem_data_i;
    assign s.flush     = frame_end_i;

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr_o <= fetch_addr;               // held for the whole handshake
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_req_o  <= 1'b0;
            ack_wait   <= 1'b0;
            discard    <= 1'b0;
            fetch_on   <= 1'b1;
            line_addr  <= `RST_DISP_ADDR;
            fetch_addr <= `RST_DISP_ADDR;
            word_cnt   <= '0;
            line_cnt   <= '0;
        end else begin
            if (capture) begin
                mem_req_o <= 1'b0;
                ack_wait  <= 1'b1;
                discard   <= 1'b0;
            end else if (issue) begin
                mem_req_o <= 1'b1;
                ack_wait  <= 1'b0;
            end else if (!mem_ack_i) begin
                ack_wait  <= 1'b0;
            end

            if (s.push) begin
                if (word_cnt == word_last) begin    // line done, step to next line
                    word_cnt   <= '0;
                    line_addr  <= line_addr + line_len_i;
                    fetch_addr <= line_addr + line_len_i;
                    if (line_cnt == 2'(`V_VISIBLE - 1)) begin
                        fetch_on <= 1'b0;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                    end
                end else begin
                    word_cnt   <= word_cnt + 1'b1;
                    fetch_addr <= fetch_addr + 1'b1;
                end
            end

            if (frame_end_i) begin                  // restart for the next frame
                line_addr  <= disp_addr_i;
                fetch_addr <= disp_addr_i;
                word_cnt   <= '0;
                line_cnt   <= '0;
                fetch_on   <= 1'b1;
                if (mem_req_o && !mem_ack_i) begin
                    discard <= 1'b1;                // stale word still in flight
                end
            end
        end
    end

endmodule

//--- hdl/video_regs.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               reg_wr_i,
    input  logic [2:0]         reg_num_i,
    input  video_pkg::word_t   reg_data_i,
    output video_pkg::word_t   reg_data_o,
    input  logic [`V_BITS-1:0] v_count_i,
    input  logic               visible_end_i,
    input  logic               underrun_i,
    output video_pkg::color_t  border_o,
    output video_pkg::color_t  colorbase_o,
    output logic               blank_o,
    output video_pkg::bpp_t    bpp_o,
    output video_pkg::addr_t   disp_addr_o,
    output video_pkg::word_t   line_len_o,
    output logic               frame_intr_o
);

    logic             underrun_flag;               // sticky until a status write
    video_pkg::word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_o      <= `RST_BORDER;
            colorbase_o   <= `RST_COLORBASE;
            blank_o       <= `RST_BLANK;
            bpp_o         <= `RST_BPP;
            disp_addr_o   <= `RST_DISP_ADDR;
            line_len_o    <= `RST_LINE_LEN;
            underrun_flag <= 1'b0;
            frame_intr_o  <= 1'b0;
        end else begin
            frame_intr_o <= visible_end_i;
            if (underrun_i) begin
                underrun_flag <= 1'b1;
            end
            if (reg_wr_i) begin
                case (reg_num_i)
                    `REG_VID_CTRL:  border_o <= reg_data_i[7:0];
                    `REG_GFX_CTRL: begin
                        colorbase_o <= reg_data_i[15:8];
                        blank_o     <= reg_data_i[7];
                        bpp_o       <= reg_data_i[4];
                    end
                    `REG_DISP_ADDR: disp_addr_o <= reg_data_i;
                    `REG_LINE_LEN:  line_len_o <= reg_data_i;
                    `REG_STATUS:    underrun_flag <= 1'b0;   // any write clears
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_num_i)
            `REG_VID_CTRL:  rd_data = {8'h00, border_o};
            `REG_GFX_CTRL:  rd_data = {colorbase_o, blank_o, 2'b00, bpp_o, 4'h0};
            `REG_DISP_ADDR: rd_data = disp_addr_o;
            `REG_LINE_LEN:  rd_data = line_len_o;
            `REG_STATUS: begin
                rd_data     = 16'(v_count_i);
                rd_data[15] = underrun_flag;
            end
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;                      // one cycle read latency
    end

endmodule

//--- hdl/video_timing.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_timing (
    input  logic               clk,
    input  logic               reset_i,
    output logic [`H_BITS-1:0] h_count_o,
    output logic [`V_BITS-1:0] v_count_o,
    output logic               h_visible_o,
    output logic               v_visible_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               line_end_o,     // last clock of a line
    output logic               frame_end_o,    // last clock of the frame
    output logic               visible_end_o   // last visible pixel of the frame
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else begin
            h_count_o <= h_count_o + 1'b1;
            if (line_end_o) begin
                h_count_o <= '0;
                v_count_o <= v_count_o + 1'b1;
                if (frame_end_o) begin
                    v_count_o <= '0;
                end
            end
        end
    end

    // left part of each line and top lines of the frame are blanked
    assign h_visible_o   = h_count_o >= `H_BITS'(`H_BLANK);
    assign v_visible_o   = v_count_o >= `V_BITS'(`V_BLANK);
    assign hsync_o       = (h_count_o >= `H_BITS'(`HSYNC_START)) &&
                           (h_count_o <= `H_BITS'(`HSYNC_END));
    assign vsync_o       = v_count_o == `V_BITS'(`VSYNC_LINE);
    assign line_end_o    = h_count_o == `H_BITS'(`H_TOTAL - 1);
    assign frame_end_o   = line_end_o && (v_count_o == `V_BITS'(`V_TOTAL - 1));
    assign visible_end_o = line_end_o && h_visible_o && v_visible_o &&
                           (v_count_o == `V_BITS'(`V_TOTAL - 1));

endmodule

//--- hdl/pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if;

    logic              push;                        // write push_data this cycle
    video_pkg::word_t  push_data;
    logic              flush;                       // empty the fifo, beats push
    logic              full;
    logic              empty;
    video_pkg::word_t  head_data;                   // valid while !empty
    logic              pop;

    modport fetch   (output push, push_data, flush, input full);
    modport fifo    (input push, push_data, flush, pop, output full, empty, head_data);
    modport shifter (input head_data, empty, output pop);

endinterface

//--- hdl/video_pkg.sv
package video_pkg;

    typedef logic [15:0] word_t;                    // video ram word, register value
    typedef logic [15:0] addr_t;                    // video ram word address
    typedef logic [7:0]  color_t;                   // palette index
    typedef logic        bpp_t;                     // 0 = 4 bpp, 1 = 8 bpp

    // one video ram word seen as packed pixels, first pixel in the top bits
    typedef union packed {
        logic [3:0][3:0] p4;                        // 4 bpp, p4[3] shown first
        logic [1:0][7:0] p8;                        // 8 bpp, p8[1] shown first
    } pix_word_u;

endpackage

//--- include/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

`define H_TOTAL         64                          // clocks per line
`define H_BLANK         32                          // blanked clocks at line start
`define H_VISIBLE       (`H_TOTAL - `H_BLANK)       // visible pixels per line
`define HSYNC_START     8
`define HSYNC_END       15
`define H_BITS          6                           // horizontal counter width
`define V_TOTAL         6                           // lines per frame
`define V_BLANK         2                           // blanked lines at frame start
`define V_VISIBLE       (`V_TOTAL - `V_BLANK)
`define VSYNC_LINE      0
`define V_BITS          3                           // vertical counter width
`define FIFO_DEPTH      16                          // words, power of two

`define REG_VID_CTRL    3'd0
`define REG_GFX_CTRL    3'd1
`define REG_DISP_ADDR   3'd2
`define REG_LINE_LEN    3'd3
`define REG_STATUS      3'd4

`define RST_BORDER      8'h08                       // dark grey
`define RST_COLORBASE   8'h00
`define RST_BLANK       1'b1
`define RST_BPP         1'b1                        // 8 bpp
`define RST_DISP_ADDR   16'h0000
`define RST_LINE_LEN    16'd16

`endif
